//--- mem_stage.f
+incdir+verification
source/mem_stage_pkg.sv
source/access_wait_timer.sv
source/mem_lane_unit.sv
source/data_ram.sv
source/fence_flush_fsm.sv
source/commit_unit.sv
source/mem_stage.sv
verification/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - target: rtl
    files:
      - source/mem_stage_pkg.sv
      - source/access_wait_timer.sv
      - source/mem_lane_unit.sv
      - source/data_ram.sv
      - source/fence_flush_fsm.sv
      - source/commit_unit.sv
      - source/mem_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_mem_stage.sv

//--- verification/mem_stage_model.svh
// Shadow of the data RAM, little-endian byte order within a word
localparam int MODEL_WORDS = 256;

logic [31:0] model_mem [MODEL_WORDS];

function automatic int model_index(input logic [31:0] a);
    return int'(a[31:2] % MODEL_WORDS);
endfunction

// Initial contents, every address bit takes part
function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
endfunction

function automatic logic model_misaligned(input mem_width_t w, input logic [31:0] a);
    if (w == LH || w == LHU) begin
        return a[0];
    end
    if (w == LW) begin
        return a[1:0] != 2'b00;
    end
    return 1'b0;
endfunction

function automatic logic [31:0] width_mask(input mem_width_t w);
    case (w)
        LB, LBU: return 32'h0000_00ff;
        LH, LHU: return 32'h0000_ffff;
        LW:      return 32'hffff_ffff;
        default: return 32'h0000_0000;
    endcase
endfunction

// Byte, halfword or word placed at its byte offset
function automatic void model_store(input mem_width_t w, input logic [31:0] a,
                                    input logic [31:0] d);
    int          idx;
    int          sh;
    logic [31:0] mask;
    idx  = model_index(a);
    sh   = int'(a[1:0]) * 8;
    mask = width_mask(w);
    model_mem[idx] = (model_mem[idx] & ~(mask << sh)) | ((d & mask) << sh);
endfunction

function automatic logic [31:0] model_load(input mem_width_t w, input logic [31:0] a);
    logic [31:0] raw;
    raw = model_mem[model_index(a)] >> (int'(a[1:0]) * 8);
    case (w)
        LB:      return {{24{raw[7]}}, raw[7:0]};
        LBU:     return raw & 32'h0000_00ff;
        LH:      return {{16{raw[15]}}, raw[15:0]};
        LHU:     return raw & 32'h0000_ffff;
        LW:      return raw;
        default: return 32'h0;
    endcase
endfunction

function automatic logic [31:0] model_wb(input wb_sel_t sel, input logic [31:0] load,
                                         input logic [31:0] pc4, input logic [31:0] imm_u,
                                         input logic [31:0] alu);
    if (sel == WB_PC4) return pc4;
    if (sel == WB_IMM_U) return imm_u;
    if (sel == WB_ALU) return alu;
    return load;
endfunction

//--- verification/tb_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
    import mem_stage_pkg::*;

    `include "mem_stage_model.svh"

    localparam int WAIT_STATES     = 2;
    localparam int N_FILL          = 16;
    localparam int N_RANDOM        = 200;
    localparam int N_MISALIGNED    = 24;
    localparam int N_WB            = 40;
    localparam int N_FENCE         = 8;
    localparam int N_BRANCH        = 40;
    localparam int MAX_FLUSH_DELAY = 8;
    localparam logic [31:0] WINDOW_BASE = 32'h0000_0100;

    // Every access, worst-case fence waits, plus margin
    localparam int CYCLE_LIMIT = (N_FILL + N_RANDOM + 2 * N_MISALIGNED) * (WAIT_STATES + 1)
                               + N_FENCE * (2 * MAX_FLUSH_DELAY + 6)
                               + N_WB + N_BRANCH + 200;

    logic        CLK;
    logic        nRST;
    ex_mem_t     ex_mem;
    logic        iflush_done;
    logic        dflush_done;
    hazard_rpt_t hazard;
    logic [31:0] reg_wdata;
    logic        iflush_req;
    logic        dflush_req;
    logic        update_predictor;
    logic        branch_result;
    logic [31:0] update_addr;
    logic        halt;

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count;

    mem_stage u_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .ex_mem          (ex_mem),
        .iflush_done     (iflush_done),
        .dflush_done     (dflush_done),
        .hazard          (hazard),
        .reg_wdata       (reg_wdata),
        .iflush_req      (iflush_req),
        .dflush_req      (dflush_req),
        .update_predictor(update_predictor),
        .branch_result   (branch_result),
        .update_addr     (update_addr),
        .halt            (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED time %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before,
                               input int checks_before);
        $display("%-24s checks %0d, errors %0d", name,
                 check_count - checks_before, error_count - errors_before);
    endtask

    task automatic clear_request();
        ex_mem.dren  = 1'b0;
        ex_mem.dwen  = 1'b0;
        ex_mem.width = NONE;
    endtask

    // One access held until busy falls, checked in its completing cycle
    task automatic access_mem(input mem_width_t w, input logic [31:0] a,
                              input logic is_store, input logic [31:0] d);
        int          busy_cycles;
        logic [31:0] expected;
        ex_mem.dren     = !is_store;
        ex_mem.dwen     = is_store;
        ex_mem.width    = w;
        ex_mem.addr     = a;
        ex_mem.rs2_data = d;
        ex_mem.w_sel    = WB_LOAD;
        expected        = model_load(w, a);
        busy_cycles     = 0;
        @(negedge CLK);
        while (hazard.d_mem_busy) begin
            busy_cycles++;
            @(negedge CLK);
        end
        check_value(busy_cycles, WAIT_STATES, $sformatf("busy cycles at %h", a));
        check_value(hazard.mal_l | hazard.mal_s, 1'b0, $sformatf("aligned flag at %h", a));
        if (!is_store) begin
            check_value(reg_wdata, expected, $sformatf("load data at %h", a));
        end
        @(posedge CLK);
        #1;
        if (is_store) begin
            model_store(w, a, d);
        end
        clear_request();
    endtask

    task automatic fill_window();
        logic [31:0] a;
        for (int i = 0; i < N_FILL; i++) begin
            a = WINDOW_BASE + 32'(4 * i);
            access_mem(LW, a, 1'b1, fill_pattern(a));
        end
    endtask

    task automatic random_loads_stores();
        mem_width_t  w;
        logic [31:0] a;
        logic        st;
        for (int i = 0; i < N_RANDOM; i++) begin
            w = mem_width_t'($unsigned($random(seed)) % 5);
            a = WINDOW_BASE + ($random(seed) & 32'h3f);
            if (w == LW) begin
                a[1:0] = 2'b00;
            end else if (w == LH || w == LHU) begin
                a[0] = 1'b0;
            end
            st = ($random(seed) & 1) != 0;
            access_mem(w, a, st, $random(seed));
        end
    endtask

    task automatic misaligned_accesses();
        mem_width_t  w;
        logic [31:0] a;
        logic [31:0] epc;
        logic        st;
        for (int i = 0; i < N_MISALIGNED; i++) begin
            if (($random(seed) & 1) != 0) begin
                w = (($random(seed) & 1) != 0) ? LH : LHU;
                a = WINDOW_BASE + ($random(seed) & 32'h3c) + 32'(1 + 2 * ($random(seed) & 1));
            end else begin
                w = LW;
                a = WINDOW_BASE + ($random(seed) & 32'h3c) + 1 + ($unsigned($random(seed)) % 3);
            end
            st              = ($random(seed) & 1) != 0;
            epc             = $random(seed);
            ex_mem.dren     = !st;
            ex_mem.dwen     = st;
            ex_mem.width    = w;
            ex_mem.addr     = a;
            ex_mem.pc       = epc;
            ex_mem.rs2_data = $random(seed);
            // Held as long as an aligned access would take
            for (int cyc = 0; cyc <= WAIT_STATES; cyc++) begin
                @(negedge CLK);
                check_value(hazard.d_mem_busy, 1'b0, "busy on misaligned access");
                check_value(hazard.mal_l, !st & model_misaligned(w, a), "mal_l");
                check_value(hazard.mal_s, st & model_misaligned(w, a), "mal_s");
                check_value(hazard.badaddr, a, "badaddr");
                check_value(hazard.epc, epc, "epc");
                @(posedge CLK);
                #1;
            end
            clear_request();
            // Memory must still hold the old word
            access_mem(LW, {a[31:2], 2'b00}, 1'b0, 32'h0);
        end
    endtask

    task automatic writeback_select();
        wb_sel_t sel;
        for (int i = 0; i < N_WB; i++) begin
            sel              = wb_sel_t'(1 + $unsigned($random(seed)) % 3);
            ex_mem.w_sel     = sel;
            ex_mem.pc4       = $random(seed);
            ex_mem.imm_u     = $random(seed) & 32'hffff_f000;
            ex_mem.addr      = $random(seed);
            ex_mem.rd        = 5'($random(seed));
            ex_mem.reg_write = ($random(seed) & 1) != 0;
            @(negedge CLK);
            check_value(reg_wdata, model_wb(sel, 32'h0, ex_mem.pc4, ex_mem.imm_u, ex_mem.addr),
                        "reg_wdata");
            check_value(hazard.rd, ex_mem.rd, "rd");
            check_value(hazard.reg_write, ex_mem.reg_write, "reg_write");
            check_value(hazard.d_mem_busy, 1'b0, "busy without access");
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic fence_sequence();
        int i_dly;
        int d_dly;
        int later;
        for (int n = 0; n < N_FENCE; n++) begin
            i_dly = 1 + ($random(seed) & 7);
            d_dly = 1 + ($random(seed) & 7);
            if (($random(seed) & 3) == 0) begin
                d_dly = i_dly;
            end
            later = (i_dly > d_dly) ? i_dly : d_dly;
            ex_mem.ifence = 1'b1;
            @(negedge CLK);
            check_value({iflush_req, dflush_req}, 2'b11, "flush requests on fence");
            check_value(hazard.fence_stall, 1'b1, "stall on fence");
            // ifence stays high, so HOLD must not start a second fence
            for (int cyc = 1; cyc <= later + 2; cyc++) begin
                @(posedge CLK);
                #1;
                iflush_done = (cyc == i_dly);
                dflush_done = (cyc == d_dly);
                @(negedge CLK);
                check_value({iflush_req, dflush_req}, 2'b00, "flush requests while waiting");
                check_value(hazard.fence_stall, cyc <= later, $sformatf("stall cycle %0d", cyc));
            end
            @(posedge CLK);
            #1;
            iflush_done   = 1'b0;
            dflush_done   = 1'b0;
            ex_mem.ifence = 1'b0;
            @(negedge CLK);
            check_value(hazard.fence_stall, 1'b0, "stall after fence drop");
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic branch_reporting();
        logic exp_mispredict;
        for (int i = 0; i < N_BRANCH; i++) begin
            ex_mem.branch       = ($random(seed) & 1) != 0;
            ex_mem.prediction   = ($random(seed) & 1) != 0;
            ex_mem.branch_taken = ($random(seed) & 1) != 0;
            ex_mem.brj_addr     = $random(seed);
            ex_mem.halt         = ($random(seed) & 7) == 0;
            // A resolved branch whose outcome differs from its prediction
            exp_mispredict = 1'b0;
            if (ex_mem.branch && ex_mem.prediction != ex_mem.branch_taken) begin
                exp_mispredict = 1'b1;
            end
            @(negedge CLK);
            check_value(hazard.mispredict, exp_mispredict, "mispredict");
            check_value(update_predictor, ex_mem.branch, "update_predictor");
            check_value(branch_result, ex_mem.branch_taken, "branch_result");
            check_value(update_addr, ex_mem.brj_addr, "update_addr");
            check_value(halt, ex_mem.halt, "halt");
            check_value(hazard.halt, ex_mem.halt, "hazard halt");
            @(posedge CLK);
            #1;
        end
        ex_mem.halt = 1'b0;
    endtask

    initial begin
        int e0;
        int c0;
        seed        = 32'h2a6c_ef78;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        nRST        = 1'b0;
        ex_mem      = '0;
        ex_mem.width = NONE;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        e0 = error_count;
        c0 = check_count;
        fill_window();
        random_loads_stores();
        report_test("random loads/stores", e0, c0);
        e0 = error_count;
        c0 = check_count;
        misaligned_accesses();
        report_test("misaligned accesses", e0, c0);
        e0 = error_count;
        c0 = check_count;
        writeback_select();
        report_test("writeback select", e0, c0);
        e0 = error_count;
        c0 = check_count;
        fence_sequence();
        report_test("fence", e0, c0);
        e0 = error_count;
        c0 = check_count;
        branch_reporting();
        report_test("branch and halt", e0, c0);

        $display("Total checks %0d, errors %0d, cycles %0d", check_count, error_count,
                 cycle_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter     BUS_ENDIANNESS = "little",
    parameter int WAIT_STATES    = 2,
    parameter int RAM_WORDS      = 256
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  mem_stage_pkg::ex_mem_t     ex_mem,
    input  logic                       iflush_done,
    input  logic                       dflush_done,
    output mem_stage_pkg::hazard_rpt_t hazard,
    output logic [31:0]                reg_wdata,
    output logic                       iflush_req,
    output logic                       dflush_req,
    output logic                       update_predictor,
    output logic                       branch_result,
    output logic [31:0]                update_addr,
    output logic                       halt
);
    import mem_stage_pkg::*;

    bus_req_t    bus_req;
    logic [31:0] rdata;
    logic [31:0] load_data;
    logic        busy;
    logic        mal;
    logic        fence_stall;

    mem_lane_unit #(
        .BUS_ENDIANNESS(BUS_ENDIANNESS)
    ) u_lane (
        .ex_mem   (ex_mem),
        .rdata    (rdata),
        .bus_req  (bus_req),
        .load_data(load_data),
        .mal      (mal)
    );

    data_ram #(
        .WAIT_STATES(WAIT_STATES),
        .RAM_WORDS  (RAM_WORDS)
    ) u_ram (
        .CLK    (CLK),
        .nRST   (nRST),
        .bus_req(bus_req),
        .rdata  (rdata),
        .busy   (busy)
    );

    fence_flush_fsm u_fence (
        .CLK        (CLK),
        .nRST       (nRST),
        .ifence     (ex_mem.ifence),
        .iflush_done(iflush_done),
        .dflush_done(dflush_done),
        .iflush_req (iflush_req),
        .dflush_req (dflush_req),
        .fence_stall(fence_stall)
    );

    commit_unit u_commit (
        .ex_mem          (ex_mem),
        .load_data       (load_data),
        .mal             (mal),
        .busy            (busy),
        .fence_stall     (fence_stall),
        .hazard          (hazard),
        .reg_wdata       (reg_wdata),
        .update_predictor(update_predictor),
        .branch_result   (branch_result),
        .update_addr     (update_addr),
        .halt            (halt)
    );

endmodule

`default_nettype wire

//--- source/commit_unit.sv
`timescale 1ns/100ps
`default_nettype none

module commit_unit (
    input  mem_stage_pkg::ex_mem_t     ex_mem,
    input  logic [31:0]                load_data,
    input  logic                       mal,
    input  logic                       busy,
    input  logic                       fence_stall,
    output mem_stage_pkg::hazard_rpt_t hazard,
    output logic [31:0]                reg_wdata,
    output logic                       update_predictor,
    output logic                       branch_result,
    output logic [31:0]                update_addr,
    output logic                       halt
);
    import mem_stage_pkg::*;

    // Writeback source
    always_comb begin
        case (ex_mem.w_sel)
            WB_LOAD:  reg_wdata = load_data;
            WB_PC4:   reg_wdata = ex_mem.pc4;
            WB_IMM_U: reg_wdata = ex_mem.imm_u;
            WB_ALU:   reg_wdata = ex_mem.addr;
            default:  reg_wdata = '0;
        endcase
    end

    always_comb begin
        hazard.d_mem_busy  = busy;
        hazard.fence_stall = fence_stall;

        // Misalignment exceptions only for real accesses
        hazard.mal_l   = ex_mem.dren & mal;
        hazard.mal_s   = ex_mem.dwen & mal;
        hazard.badaddr = ex_mem.addr;
        hazard.epc     = ex_mem.pc;

        // Non-branches never mispredict
        hazard.mispredict = ex_mem.branch & (ex_mem.prediction ^ ex_mem.branch_taken);

        hazard.halt      = ex_mem.halt;
        hazard.rd        = ex_mem.rd;
        hazard.reg_write = ex_mem.reg_write;
    end

    // Predictor update
    assign update_predictor = ex_mem.branch;
    assign branch_result    = ex_mem.branch_taken;
    assign update_addr      = ex_mem.brj_addr;

    assign halt = ex_mem.halt;

endmodule

`default_nettype wire

//--- source/fence_flush_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module fence_flush_fsm (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic iflush_req,
    output logic dflush_req,
    output logic fence_stall
);

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WAIT_BOTH = 3'd1,
        WAIT_I    = 3'd2,
        WAIT_D    = 3'd3,
        HOLD      = 3'd4
    } fence_state_t;

    fence_state_t state;
    fence_state_t next_state;
    logic         fence_start;
    logic         iflushed;
    logic         dflushed;

    // IDLE is only re-entered with ifence low, so a high level here is an edge
    assign fence_start = (state == IDLE) && ifence;
    assign iflush_req  = fence_start;
    assign dflush_req  = fence_start;

    assign iflushed = (state == IDLE) || (state == WAIT_D) || (state == HOLD);
    assign dflushed = (state == IDLE) || (state == WAIT_I) || (state == HOLD);

    assign fence_stall = fence_start || !(iflushed && dflushed);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (ifence) next_state = WAIT_BOTH;
            WAIT_BOTH: begin
                if (iflush_done && dflush_done) begin
                    next_state = HOLD;
                end else if (iflush_done) begin
                    next_state = WAIT_D;
                end else if (dflush_done) begin
                    next_state = WAIT_I;
                end
            end
            WAIT_I:    if (iflush_done) next_state = HOLD;
            WAIT_D:    if (dflush_done) next_state = HOLD;
            // Wait for the fence to leave the stage
            HOLD:      if (!ifence) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int WAIT_STATES = 2,
    parameter int RAM_WORDS   = 256
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  mem_stage_pkg::bus_req_t bus_req,
    output logic [31:0]             rdata,
    output logic                    busy
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [3:0][7:0] mem [RAM_WORDS];
    logic [AW-1:0]   ram_idx;
    logic            access;
    logic            write_now;

    assign access = bus_req.ren | bus_req.wen;

    access_wait_timer #(
        .WAIT_STATES(WAIT_STATES)
    ) u_wait_timer (
        .CLK  (CLK),
        .nRST (nRST),
        .start(access),
        .busy (busy)
    );

    // Word index wraps around the depth
    assign ram_idx = AW'(bus_req.addr[31:2] % RAM_WORDS);

    // Commit a write at the end of the completing cycle
    assign write_now = bus_req.wen && !busy;

    always_ff @(posedge CLK) begin
        if (write_now) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_req.byte_en[i]) begin
                    mem[ram_idx][i] <= bus_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = bus_req.ren ? mem[ram_idx] : '0;

endmodule

`default_nettype wire

//--- source/mem_lane_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mem_lane_unit #(
    parameter BUS_ENDIANNESS = "little"
) (
    input  mem_stage_pkg::ex_mem_t  ex_mem,
    input  logic [31:0]             rdata,
    output mem_stage_pkg::bus_req_t bus_req,
    output logic [31:0]             load_data,
    output logic                    mal
);
    import mem_stage_pkg::*;

    logic [1:0]  byte_offset;
    logic [3:0]  byte_en_std;
    logic [3:0]  bus_byte_en;
    logic [31:0] store_data;
    logic [31:0] bus_wdata;
    data_word_u  load_word;

    function automatic logic [31:0] swap_lanes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign byte_offset = ex_mem.addr[1:0];

    // Standard little-endian lane enables
    always_comb begin
        case (ex_mem.width)
            LB, LBU: byte_en_std = 4'b0001 << byte_offset;
            LH, LHU: byte_en_std = byte_offset[1] ? 4'b1100 : 4'b0011;
            LW:      byte_en_std = 4'b1111;
            default: byte_en_std = 4'b0000;
        endcase
    end

    // Odd halfword or unaligned word
    always_comb begin
        case (ex_mem.width)
            LH, LHU: mal = byte_offset[0];
            LW:      mal = (byte_offset != 2'b00);
            default: mal = 1'b0;
        endcase
    end

    // Store data copied into every lane it could land in
    always_comb begin
        case (ex_mem.width)
            LB, LBU: store_data = {4{ex_mem.rs2_data[7:0]}};
            LH, LHU: store_data = {2{ex_mem.rs2_data[15:0]}};
            LW:      store_data = ex_mem.rs2_data;
            default: store_data = '0;
        endcase
    end

    generate
        if (BUS_ENDIANNESS == "big") begin : g_big_endian
            // Lane 0 of the bus is the most significant byte
            assign bus_byte_en = {byte_en_std[0], byte_en_std[1],
                                  byte_en_std[2], byte_en_std[3]};
            assign bus_wdata   = swap_lanes(store_data);
            assign load_word   = swap_lanes(rdata);
        end else begin : g_little_endian
            assign bus_byte_en = byte_en_std;
            assign bus_wdata   = store_data;
            assign load_word   = rdata;
        end
    endgenerate

    always_comb begin
        bus_req.ren     = ex_mem.dren & ~mal;
        bus_req.wen     = ex_mem.dwen & ~mal;
        bus_req.byte_en = bus_byte_en;
        bus_req.addr    = ex_mem.addr;
        bus_req.wdata   = bus_wdata;
    end

    // Pick the addressed lane and extend it
    always_comb begin
        case (ex_mem.width)
            LB:      load_data = {{24{load_word.bytes[byte_offset][7]}},
                                  load_word.bytes[byte_offset]};
            LBU:     load_data = {24'h0, load_word.bytes[byte_offset]};
            LH:      load_data = {{16{load_word.halves[byte_offset[1]][15]}},
                                  load_word.halves[byte_offset[1]]};
            LHU:     load_data = {16'h0, load_word.halves[byte_offset[1]]};
            LW:      load_data = load_word;
            default: load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/access_wait_timer.sv
`timescale 1ns/100ps
`default_nettype none

module access_wait_timer #(
    parameter int WAIT_STATES = 2
) (
    input  logic CLK,
    input  logic nRST,
    input  logic start,
    output logic busy
);

    localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [CW-1:0] count;

    // High for the wait states, low in the completing cycle
    assign busy = start && (count < CW'(WAIT_STATES));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
        end else begin
            // Idle or completing, next request starts from zero
            count <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // Access width and signedness, also picks the store replication
    typedef enum logic [2:0] {
        LB   = 3'd0,
        LBU  = 3'd1,
        LH   = 3'd2,
        LHU  = 3'd3,
        LW   = 3'd4,
        NONE = 3'd5
    } mem_width_t;

    // Source of the register write data
    typedef enum logic [1:0] {
        WB_LOAD  = 2'd0,
        WB_PC4   = 2'd1,
        WB_IMM_U = 2'd2,
        WB_ALU   = 2'd3
    } wb_sel_t;

    // ex/mem pipeline register
    typedef struct packed {
        logic        dren;
        logic        dwen;
        mem_width_t  width;
        logic [31:0] addr;
        logic [31:0] rs2_data;
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] imm_u;
        wb_sel_t     w_sel;
        logic [4:0]  rd;
        logic        reg_write;
        logic        ifence;
        logic        halt;
        logic        branch;
        logic        prediction;
        logic        branch_taken;
        logic [31:0] brj_addr;
    } ex_mem_t;

    // Report toward the hazard unit
    typedef struct packed {
        logic        d_mem_busy;
        logic        fence_stall;
        logic        mal_l;
        logic        mal_s;
        logic [31:0] badaddr;
        logic [31:0] epc;
        logic        mispredict;
        logic        halt;
        logic [4:0]  rd;
        logic        reg_write;
    } hazard_rpt_t;

    // One data word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

    // Request from the lane unit to the data RAM
    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [3:0]  byte_en;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

endpackage

`default_nettype wire
